// File: dv/lsu_testdata.txt
// ctrl addr wdata rd expected, expected is the load result and unused on stores
// ctrl bits 3:0 hold the LSU code, bit 4 issues on the cycle after the previous entry
0A 00000080 00000013 00 00000000
0A 00000084 00500093 00 00000000
0A 00000088 00108113 00 00000000
0A 0000008C 002081B3 00 00000000
08 00000091 000000AB 00 00000000
09 00000096 0000BEEF 00 00000000
0A 00000010 DEADBEEF 00 00000000
12 00000010 00000000 05 DEADBEEF
0A 00000020 11223344 00 00000000
08 00000020 000000A0 00 00000000
08 00000021 000000B1 00 00000000
08 00000022 000000C2 00 00000000
08 00000023 000000D3 00 00000000
02 00000020 00000000 06 D3C2B1A0
0A 00000024 55667788 00 00000000
09 00000024 0000E1F2 00 00000000
02 00000024 00000000 07 5566E1F2
09 00000026 00009A8B 00 00000000
02 00000024 00000000 08 9A8BE1F2
00 00000020 00000000 09 FFFFFFA0
04 00000020 00000000 0A 000000A0
00 00000023 00000000 0B FFFFFFD3
04 00000022 00000000 0C 000000C2
01 00000022 00000000 0D FFFFD3C2
05 00000022 00000000 0E 0000D3C2
01 00000020 00000000 0F FFFFB1A0
05 00000024 00000000 10 0000E1F2
0A 00000028 127F6A05 00 00000000
00 00000029 00000000 11 0000006A
01 0000002A 00000000 12 0000127F
02 00000010 00000000 13 DEADBEEF
12 00000024 00000000 14 9A8BE1F2
11 00000012 00000000 15 FFFFDEAD
14 00000011 00000000 16 000000BE
10 00000027 00000000 17 FFFFFF9A
02 00000090 00000000 18 0000AB00
12 00000094 00000000 19 BEEF0000

// File: files.f
+incdir+hw
hw/lsu_pkg.sv
hw/bram_sp.sv
hw/mem_arbiter.sv
hw/ifetch_unit.sv
hw/lsu_unit.sv
hw/lsu_mem_top.sv
dv/tb_lsu_mem_top.sv

// File: Bender.yml
package:
  name: lsu_mem

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsu_pkg.sv
      - hw/bram_sp.sv
      - hw/mem_arbiter.sv
      - hw/ifetch_unit.sv
      - hw/lsu_unit.sv
      - hw/lsu_mem_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_lsu_mem_top.sv

// File: dv/tb_lsu_mem_top.sv
// LSU memory subsystem testbench

`timescale 1ns/1ps

`include "lsu_defines.svh"

module tb_lsu_mem_top;

  localparam int MAX_ENTRIES = 64;
  localparam int COLS        = 5;    // ctrl, addr, wdata, rd, expected

  logic                        clk_i;
  logic                        rstn_i;
  logic                        lsu_ctrl_valid_i;
  lsu_pkg::lsu_ctrl_e          lsu_ctrl_i;
  logic [`DATA_WIDTH-1:0]      lsu_addr_i;
  logic [`DATA_WIDTH-1:0]      lsu_wdata_i;
  logic [`REG_ADDR_WIDTH-1:0]  lsu_regdest_i;
  logic [`DATA_WIDTH-1:0]      lsu_rdata_o;
  logic                        lsu_rf_wb_o;
  logic [`REG_ADDR_WIDTH-1:0]  lsu_regdest_o;
  logic                        fetch_en_i;
  logic [`DATA_WIDTH-1:0]      instr_o;
  logic [`DATA_WIDTH-1:0]      instr_addr_o;
  logic                        instr_valid_o;

  logic [31:0] vec_mem [MAX_ENTRIES*COLS];     // Raw vectors, x past the last entry
  logic [31:0] ref_mem [`MEM_WORDS];           // Expected RAM contents

  // Pending loads, oldest first
  logic [31:0]                exp_data_q [$];
  logic [`REG_ADDR_WIDTH-1:0] exp_rd_q   [$];
  int                         exp_edge_q [$];

  integer      seed = 32'hd0d;
  int          cyc = 0;
  int          cyc_limit = 0;
  int          n_entries = 0;
  int          load_errs = 0;
  int          fetch_errs = 0;
  int          other_errs = 0;
  int          n_loads = 0;
  int          n_instr = 0;
  bit          fetch_started = 1'b0;
  logic [31:0] exp_pc = `BOOT_ADDR;

  lsu_mem_top i_lsu_mem_top (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;   // 4 ns period

  ////////////////////////////////////////////////////////////
  // Cycle count and watchdog
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc_limit > 0 && cyc >= cyc_limit) begin
      $display("Timeout: run still busy after %0d cycles", cyc_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Lanes touched by a store of the given size
  function automatic logic [3:0] lane_enables(input logic [1:0] size, input logic [1:0] lane);
    case (size)
      2'd0:    return 4'b0001 << lane;
      2'd1:    return lane[1] ? 4'b1100 : 4'b0011;   // Aligned half
      default: return 4'b1111;
    endcase
  endfunction

  task automatic model_store(input logic [1:0] size, input logic [31:0] addr,
                             input logic [31:0] wdata);
    logic [3:0]  be;
    logic [31:0] lanes;
    int          w;
    be    = lane_enables(size, addr[1:0]);
    lanes = wdata << (8 * addr[1:0]);               // Byte 0 of wdata into its lane
    w     = addr[`MEM_AW+1:2];
    for (int b = 0; b < 4; b++) begin
      if (be[b]) ref_mem[w][8*b +: 8] = lanes[8*b +: 8];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Drives one vector, called right after a rising edge
  task automatic issue_entry(input int idx);
    logic [31:0] ctrl_w;
    logic [31:0] addr_w;
    logic [31:0] wdata_w;
    logic [31:0] rd_w;
    logic [3:0]  code;
    ctrl_w  = vec_mem[idx*COLS];
    addr_w  = vec_mem[idx*COLS+1];
    wdata_w = vec_mem[idx*COLS+2];
    rd_w    = vec_mem[idx*COLS+3];
    code    = ctrl_w[3:0];
    lsu_ctrl_valid_i <= 1'b1;
    lsu_ctrl_i       <= lsu_pkg::lsu_ctrl_e'(code);
    lsu_addr_i       <= addr_w;
    lsu_wdata_i      <= wdata_w;
    lsu_regdest_i    <= rd_w[`REG_ADDR_WIDTH-1:0];
    if (code[3]) begin
      model_store(code[1:0], addr_w, wdata_w);
    end else begin
      exp_data_q.push_back(vec_mem[idx*COLS+4]);
      exp_rd_q.push_back(rd_w[`REG_ADDR_WIDTH-1:0]);
      exp_edge_q.push_back(cyc + 4);   // DUT samples next edge, writeback two later
    end
  endtask

  initial begin
    int          idx;
    int          gap;
    int          fetch_after;
    logic [31:0] ctrl_w;
    lsu_ctrl_valid_i = 1'b0;
    lsu_ctrl_i       = lsu_pkg::LW;
    lsu_addr_i       = '0;
    lsu_wdata_i      = '0;
    lsu_regdest_i    = '0;
    fetch_en_i       = 1'b0;
    rstn_i           = 1'b0;
    for (int w = 0; w < `MEM_WORDS; w++) ref_mem[w] = '0;
    $readmemh("dv/lsu_testdata.txt", vec_mem);

    // Count entries, find the last store into the fetch region
    fetch_after = -1;
    while (n_entries < MAX_ENTRIES && !$isunknown(vec_mem[n_entries*COLS])) begin
      ctrl_w = vec_mem[n_entries*COLS];
      if (ctrl_w[3] && vec_mem[n_entries*COLS+1] >= `BOOT_ADDR) fetch_after = n_entries;
      n_entries++;
    end
    cyc_limit = 4 * n_entries + 200;

    repeat (5) @(posedge clk_i);
    rstn_i <= 1'b1;
    if (fetch_after < 0) begin
      fetch_en_i    <= 1'b1;
      fetch_started  = 1'b1;
    end

    for (idx = 0; idx < n_entries; idx++) begin
      ctrl_w = vec_mem[idx*COLS];
      if (!ctrl_w[4]) begin                  // Bit 4 asks for no idle gap
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) begin
          @(posedge clk_i);
          lsu_ctrl_valid_i <= 1'b0;
        end
      end
      @(posedge clk_i);
      issue_entry(idx);
      // Boot code is in place, start fetching
      if (idx == fetch_after) begin
        @(posedge clk_i);
        lsu_ctrl_valid_i <= 1'b0;
        fetch_en_i       <= 1'b1;
        fetch_started     = 1'b1;
      end
    end
    @(posedge clk_i);
    lsu_ctrl_valid_i <= 1'b0;

    while (exp_data_q.size() != 0) @(posedge clk_i);   // Watchdog bounds this
    repeat (8) @(posedge clk_i);                       // Trailing fetches

    if (n_instr == 0) begin
      other_errs++;
      $display("No instruction came back from the fetch unit");
    end
    $display("Checked %0d loads and %0d fetches: %0d load errors, %0d fetch errors, %0d other",
             n_loads, n_instr, load_errs, fetch_errs, other_errs);
    if (load_errs + fetch_errs + other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Response checks, sampled on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic compare_writeback();
    logic [31:0]                exp_data;
    logic [`REG_ADDR_WIDTH-1:0] exp_rd;
    int                         exp_edge;
    if (exp_data_q.size() == 0) begin
      other_errs++;
      $display("Register writeback at cycle %0d with no load pending", cyc);
      return;
    end
    exp_data = exp_data_q.pop_front();
    exp_rd   = exp_rd_q.pop_front();
    exp_edge = exp_edge_q.pop_front();
    n_loads++;
    if (lsu_rdata_o !== exp_data) begin
      load_errs++;
      $display("Fail lsu_rdata_o: got %h, expected %h", lsu_rdata_o, exp_data);
    end
    if (lsu_regdest_o !== exp_rd) begin
      load_errs++;
      $display("Fail lsu_regdest_o: got %h, expected %h", lsu_regdest_o, exp_rd);
    end
    if (cyc != exp_edge) begin
      other_errs++;
      $display("Load for register %0d written back at cycle %0d, not at cycle %0d",
               exp_rd, cyc, exp_edge);
    end
  endtask

  task automatic track_fetch();
    logic [31:0] exp_instr;
    exp_instr = ref_mem[exp_pc[`MEM_AW+1:2]];
    n_instr++;
    if (instr_addr_o !== exp_pc) begin
      fetch_errs++;
      $display("Fail instr_addr_o: got %h, expected %h", instr_addr_o, exp_pc);
    end
    if (instr_o !== exp_instr) begin
      fetch_errs++;
      $display("Fail instr_o: got %h, expected %h", instr_o, exp_instr);
    end
    exp_pc = exp_pc + 32'd4;   // Strictly sequential
  endtask

  always @(negedge clk_i) begin
    if (lsu_rf_wb_o === 1'b1) compare_writeback();
    if (!fetch_started && instr_valid_o !== 1'b0) begin
      other_errs++;
      $display("instr_valid_o not low at cycle %0d before fetch was enabled", cyc);
    end else if (instr_valid_o === 1'b1) begin
      track_fetch();
    end
  end

endmodule : tb_lsu_mem_top

// File: hw/lsu_mem_top.sv
// Data memory subsystem top

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_mem_top (
  input  logic                        clk_i,
  input  logic                        rstn_i,

  // Load-store request
  input  logic                        lsu_ctrl_valid_i,
  input  lsu_pkg::lsu_ctrl_e          lsu_ctrl_i,
  input  logic [`DATA_WIDTH-1:0]      lsu_addr_i,
  input  logic [`DATA_WIDTH-1:0]      lsu_wdata_i,
  input  logic [`REG_ADDR_WIDTH-1:0]  lsu_regdest_i,

  // Load writeback
  output logic [`DATA_WIDTH-1:0]      lsu_rdata_o,
  output logic                        lsu_rf_wb_o,
  output logic [`REG_ADDR_WIDTH-1:0]  lsu_regdest_o,

  // Fetch
  input  logic                        fetch_en_i,
  output logic [`DATA_WIDTH-1:0]      instr_o,
  output logic [`DATA_WIDTH-1:0]      instr_addr_o,
  output logic                        instr_valid_o
);

  // LSU to arbiter
  logic                     lsu_req, lsu_we, lsu_rvalid;
  logic [`LSU_BE_WIDTH-1:0] lsu_be;
  logic [`MEM_AW-1:0]       lsu_addr;
  logic [`DATA_WIDTH-1:0]   lsu_wdata, lsu_rdata;

  // Fetch to arbiter
  logic                     fetch_req, fetch_gnt, fetch_rvalid;
  logic [`MEM_AW-1:0]       fetch_addr;
  logic [`DATA_WIDTH-1:0]   fetch_rdata;

  // Arbiter to RAM
  logic                     mem_en, mem_we;
  logic [`LSU_BE_WIDTH-1:0] mem_be;
  logic [`MEM_AW-1:0]       mem_addr;
  logic [`DATA_WIDTH-1:0]   mem_wdata, mem_rdata;

  lsu_unit i_lsu_unit (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .ctrl_valid_i (lsu_ctrl_valid_i),
    .ctrl_i       (lsu_ctrl_i),
    .addr_i       (lsu_addr_i),
    .wdata_i      (lsu_wdata_i),
    .regdest_i    (lsu_regdest_i),
    .rdata_o      (lsu_rdata_o),
    .rf_wb_o      (lsu_rf_wb_o),
    .regdest_o    (lsu_regdest_o),
    .lsu_req_o    (lsu_req),
    .lsu_we_o     (lsu_we),
    .lsu_be_o     (lsu_be),
    .lsu_addr_o   (lsu_addr),
    .lsu_wdata_o  (lsu_wdata),
    .lsu_rdata_i  (lsu_rdata),
    .lsu_rvalid_i (lsu_rvalid)
  );

  ifetch_unit i_ifetch_unit (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .fetch_en_i     (fetch_en_i),
    .fetch_req_o    (fetch_req),
    .fetch_addr_o   (fetch_addr),
    .fetch_gnt_i    (fetch_gnt),
    .fetch_rdata_i  (fetch_rdata),
    .fetch_rvalid_i (fetch_rvalid),
    .instr_o        (instr_o),
    .instr_addr_o   (instr_addr_o),
    .instr_valid_o  (instr_valid_o)
  );

  mem_arbiter i_mem_arbiter (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .lsu_req_i      (lsu_req),
    .lsu_we_i       (lsu_we),
    .lsu_be_i       (lsu_be),
    .lsu_addr_i     (lsu_addr),
    .lsu_wdata_i    (lsu_wdata),
    .lsu_rdata_o    (lsu_rdata),
    .lsu_rvalid_o   (lsu_rvalid),
    .fetch_req_i    (fetch_req),
    .fetch_addr_i   (fetch_addr),
    .fetch_gnt_o    (fetch_gnt),
    .fetch_rdata_o  (fetch_rdata),
    .fetch_rvalid_o (fetch_rvalid),
    .mem_en_o       (mem_en),
    .mem_we_o       (mem_we),
    .mem_be_o       (mem_be),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .mem_rdata_i    (mem_rdata)
  );

  bram_sp i_bram_sp (
    .clk_i   (clk_i),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .be_i    (mem_be),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule : lsu_mem_top

// File: hw/lsu_unit.sv
// Load-store unit

`timescale 1ns/1ps

`include "lsu_defines.svh"

module lsu_unit (
  input  logic                        clk_i,
  input  logic                        rstn_i,

  // Request from the execute stage
  input  logic                        ctrl_valid_i,
  input  lsu_pkg::lsu_ctrl_e          ctrl_i,
  input  logic [`DATA_WIDTH-1:0]      addr_i,       // Byte address
  input  logic [`DATA_WIDTH-1:0]      wdata_i,      // Store data, right aligned
  input  logic [`REG_ADDR_WIDTH-1:0]  regdest_i,    // Load target register

  // Register file writeback
  output logic [`DATA_WIDTH-1:0]      rdata_o,
  output logic                        rf_wb_o,      // One-cycle write pulse
  output logic [`REG_ADDR_WIDTH-1:0]  regdest_o,

  // Towards the arbiter
  output logic                        lsu_req_o,
  output logic                        lsu_we_o,
  output logic [`LSU_BE_WIDTH-1:0]    lsu_be_o,
  output logic [`MEM_AW-1:0]          lsu_addr_o,   // Word address
  output logic [`DATA_WIDTH-1:0]      lsu_wdata_o,  // Already in its byte lanes
  input  logic [`DATA_WIDTH-1:0]      lsu_rdata_i,  // Raw RAM word
  input  logic                        lsu_rvalid_i
);

  ////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////

  logic [`LSU_CTRL_WIDTH-1:0] ctrl_bits;
  logic                       is_write;
  logic                       is_signed;
  logic [1:0]                 size_d;
  logic [1:0]                 lane_d;
  logic [`LSU_BE_WIDTH-1:0]   be_d;

  assign ctrl_bits = ctrl_i;
  assign is_write  = ctrl_bits[`LSU_CTRL_WIDTH-1];
  assign is_signed = ~ctrl_bits[2];                // funct3[2] clear on LB/LH
  assign size_d    = ctrl_bits[1:0];
  assign lane_d    = addr_i[1:0];                  // Only picks lanes, no misalign

  // Byte enables from size and lane
  always_comb begin
    case (size_d)
      2'b00:   be_d = `LSU_BE_WIDTH'(4'b0001) << lane_d;
      2'b01:   be_d = `LSU_BE_WIDTH'(4'b0011) << {lane_d[1], 1'b0};
      default: be_d = '1;                          // Whole word
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Port request register (E0)
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      lsu_req_o <= 1'b0;
      lsu_we_o  <= 1'b0;
    end else begin
      lsu_req_o <= ctrl_valid_i;
      lsu_we_o  <= ctrl_valid_i & is_write;
    end
  end

  // Payload, meaningful only with lsu_req_o
  always_ff @(posedge clk_i) begin
    lsu_be_o    <= be_d;
    lsu_addr_o  <= addr_i[`MEM_AW+1:2];
    lsu_wdata_o <= wdata_i << {lane_d, 3'b000};   // Move into target lanes
  end

  ////////////////////////////////////////////////////////////
  // Load side stage
  ////////////////////////////////////////////////////////////

  // Stage 1 lines up with the RAM access, stage 2 with the read word
  logic [1:0]                 ld_size_q1,    ld_size_q2;
  logic                       ld_signed_q1,  ld_signed_q2;
  logic [1:0]                 ld_lane_q1,    ld_lane_q2;
  logic [`REG_ADDR_WIDTH-1:0] ld_regdest_q1, ld_regdest_q2;

  always_ff @(posedge clk_i) begin
    ld_size_q1    <= size_d;
    ld_signed_q1  <= is_signed;
    ld_lane_q1    <= lane_d;
    ld_regdest_q1 <= regdest_i;
    ld_size_q2    <= ld_size_q1;     // Shifts every cycle so two loads can overlap
    ld_signed_q2  <= ld_signed_q1;
    ld_lane_q2    <= ld_lane_q1;
    ld_regdest_q2 <= ld_regdest_q1;
  end

  ////////////////////////////////////////////////////////////
  // Load alignment and writeback (E2)
  ////////////////////////////////////////////////////////////

  logic [`DATA_WIDTH-1:0] lane_word;
  logic [`DATA_WIDTH-1:0] ld_data;

  always_comb begin
    lane_word = lsu_rdata_i >> {ld_lane_q2, 3'b000};   // Addressed byte to bit 0
    case (ld_size_q2)
      2'b00:   ld_data = {{(`DATA_WIDTH-8){ld_signed_q2 & lane_word[7]}},
                          lane_word[7:0]};
      2'b01:   ld_data = {{(`DATA_WIDTH-16){ld_signed_q2 & lane_word[15]}},
                          lane_word[15:0]};
      default: ld_data = lsu_rdata_i;                   // LW needs no shift
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      rf_wb_o <= 1'b0;
    end else begin
      rf_wb_o <= lsu_rvalid_i;   // Arbiter raises rvalid for one cycle per load
    end
  end

  always_ff @(posedge clk_i) begin
    if (lsu_rvalid_i) begin
      rdata_o   <= ld_data;
      regdest_o <= ld_regdest_q2;
    end
  end

endmodule : lsu_unit

// File: hw/ifetch_unit.sv
// Sequential instruction fetch

`timescale 1ns/1ps

`include "lsu_defines.svh"

module ifetch_unit (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  logic                    fetch_en_i,

  // Towards the arbiter
  output logic                    fetch_req_o,
  output logic [`MEM_AW-1:0]      fetch_addr_o,   // Word address
  input  logic                    fetch_gnt_i,    // Same-cycle grant
  input  logic [`DATA_WIDTH-1:0]  fetch_rdata_i,
  input  logic                    fetch_rvalid_i,

  // Towards decode
  output logic [`DATA_WIDTH-1:0]  instr_o,
  output logic [`DATA_WIDTH-1:0]  instr_addr_o,   // Byte address of instr_o
  output logic                    instr_valid_o
);

  ////////////////////////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////////////////////////

  logic [`DATA_WIDTH-1:0] pc_q;
  logic [`DATA_WIDTH-1:0] inflight_addr_q;   // PC of the access at the RAM

  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      pc_q        <= `BOOT_ADDR;
      fetch_req_o <= 1'b0;
    end else begin
      fetch_req_o <= fetch_en_i;
      if (fetch_gnt_i) begin
        pc_q <= pc_q + `DATA_WIDTH'(4);    // Held while the LSU owns the port
      end
    end
  end

  assign fetch_addr_o = pc_q[`MEM_AW+1:2];

  // Remember which PC went out, the read returns one edge later
  always_ff @(posedge clk_i) begin
    if (fetch_gnt_i) begin
      inflight_addr_q <= pc_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Instruction output
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      instr_valid_o <= 1'b0;
    end else begin
      instr_valid_o <= fetch_rvalid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_rvalid_i) begin
      instr_o      <= fetch_rdata_i;
      instr_addr_o <= inflight_addr_q;   // Still the old value on back-to-back grants
    end
  end

endmodule : ifetch_unit

// File: hw/mem_arbiter.sv
// Fixed-priority RAM port arbiter

`timescale 1ns/1ps

`include "lsu_defines.svh"

module mem_arbiter (
  input  logic                    clk_i,
  input  logic                    rstn_i,

  // Load-store side, highest priority
  input  logic                    lsu_req_i,
  input  logic                    lsu_we_i,
  input  logic [`LSU_BE_WIDTH-1:0] lsu_be_i,
  input  logic [`MEM_AW-1:0]      lsu_addr_i,
  input  logic [`DATA_WIDTH-1:0]  lsu_wdata_i,
  output logic [`DATA_WIDTH-1:0]  lsu_rdata_o,
  output logic                    lsu_rvalid_o,

  // Fetch side
  input  logic                    fetch_req_i,
  input  logic [`MEM_AW-1:0]      fetch_addr_i,
  output logic                    fetch_gnt_o,
  output logic [`DATA_WIDTH-1:0]  fetch_rdata_o,
  output logic                    fetch_rvalid_o,

  // RAM port
  output logic                    mem_en_o,
  output logic                    mem_we_o,
  output logic [`LSU_BE_WIDTH-1:0] mem_be_o,
  output logic [`MEM_AW-1:0]      mem_addr_o,
  output logic [`DATA_WIDTH-1:0]  mem_wdata_o,
  input  logic [`DATA_WIDTH-1:0]  mem_rdata_i
);

  lsu_pkg::owner_e owner_q;   // Who drove the port last cycle
  logic            rd_q;      // Last cycle was a read

  // Port mux, LSU always wins
  assign fetch_gnt_o = fetch_req_i & ~lsu_req_i;
  assign mem_en_o    = lsu_req_i | fetch_req_i;
  assign mem_we_o    = lsu_req_i & lsu_we_i;       // Fetch only reads
  assign mem_be_o    = lsu_req_i ? lsu_be_i   : '1;
  assign mem_addr_o  = lsu_req_i ? lsu_addr_i : fetch_addr_i;
  assign mem_wdata_o = lsu_wdata_i;

  always_ff @(posedge clk_i) begin
    if (rstn_i == 1'b0) begin
      owner_q <= lsu_pkg::OWNER_LSU;
      rd_q    <= 1'b0;
    end else begin
      owner_q <= lsu_req_i ? lsu_pkg::OWNER_LSU : lsu_pkg::OWNER_FETCH;
      rd_q    <= mem_en_o & ~mem_we_o;
    end
  end

  // Read word goes to both, only the owner sees rvalid
  assign lsu_rdata_o    = mem_rdata_i;
  assign fetch_rdata_o  = mem_rdata_i;
  assign lsu_rvalid_o   = rd_q & (owner_q == lsu_pkg::OWNER_LSU);
  assign fetch_rvalid_o = rd_q & (owner_q == lsu_pkg::OWNER_FETCH);

endmodule : mem_arbiter

// File: hw/bram_sp.sv
// Single-port byte-enable RAM

`timescale 1ns/1ps

`include "lsu_defines.svh"

module bram_sp (
  input  logic                     clk_i,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [`LSU_BE_WIDTH-1:0] be_i,
  input  logic [`MEM_AW-1:0]       addr_i,    // Word address
  input  logic [`DATA_WIDTH-1:0]   wdata_i,
  output logic [`DATA_WIDTH-1:0]   rdata_o    // Valid one edge after a read
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  logic [`DATA_WIDTH-1:0] mem [`MEM_WORDS];

  // Contents start cleared
  initial begin
    for (int w = 0; w < `MEM_WORDS; w++) begin
      mem[w] = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Port
  ////////////////////////////////////////////////////////////

  // No-change mode, so a write leaves rdata_o as it was
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < `LSU_BE_WIDTH; b++) begin
          if (be_i[b]) begin
            mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule : bram_sp

// File: hw/lsu_pkg.sv
// Load-store types

`include "lsu_defines.svh"

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // Load-store control code
  ////////////////////////////////////////////////////////////

  // Bit 3 marks a write, bits 2:0 mirror funct3
  // Bit 2 set on a load means zero extension
  // Bits 1:0 give the access size
  typedef enum logic [`LSU_CTRL_WIDTH-1:0] {
    LB  = 4'b0000,  // Byte, sign-extended
    LH  = 4'b0001,  // Half, sign-extended
    LW  = 4'b0010,  // Full word
    LBU = 4'b0100,  // Byte, zero-extended
    LHU = 4'b0101,  // Half, zero-extended
    SB  = 4'b1000,  // Store byte
    SH  = 4'b1001,  // Store half
    SW  = 4'b1010   // Store word
  } lsu_ctrl_e;

  ////////////////////////////////////////////////////////////
  // RAM port owner
  ////////////////////////////////////////////////////////////

  // Which requester drove the port in a given cycle
  typedef enum logic [0:0] {
    OWNER_LSU   = 1'b0,
    OWNER_FETCH = 1'b1
  } owner_e;

endpackage : lsu_pkg

// File: hw/lsu_defines.svh
// Memory subsystem parameters

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

`define DATA_WIDTH      32         // Data and byte address width
`define REG_ADDR_WIDTH  5          // Register file index
`define LSU_BE_WIDTH    4          // One enable per byte lane
`define LSU_CTRL_WIDTH  4          // Write flag plus funct3

////////////////////////////////////////////////////////////
// Memory geometry
////////////////////////////////////////////////////////////

// Depth of the shared RAM in 32-bit words
`define MEM_WORDS       256
// Word address width, log2 of MEM_WORDS
`define MEM_AW          8

////////////////////////////////////////////////////////////
// Fetch start
////////////////////////////////////////////////////////////

`define BOOT_ADDR       32'h0000_0080  // First byte address fetched

`endif
